//--- src.f
source/display_pkg.sv
source/tick_generator.sv
source/bcd_counter.sv
source/seven_seg_decoder.sv
source/digit_scanner.sv
source/segment_sequencer.sv
source/display_top.sv
test/tb_display_top.sv

//--- test/tb_display_top.sv
// ***************************************
// display testbench
// loads the counter and reads the time sliced display back
// ***************************************
`timescale 1ns/1ps

module tb_display_top
	import display_pkg::*;
();

	localparam int SLOT_BITS      = 2;
	localparam int COUNT_BITS     = 9;
	localparam int SLOT_CYCLES    = 1 << SLOT_BITS;
	localparam int DIGIT_CYCLES   = 8 * SLOT_CYCLES;            // 7 segment slots and a blank one
	localparam int FRAME_CYCLES   = num_digits * DIGIT_CYCLES;
	localparam int COUNT_CYCLES   = 1 << COUNT_BITS;            // 4 frames
	localparam int RESET_CYCLES   = 16;
	localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + RESET_CYCLES;
	localparam int MIN_FRAMES     = 20;                         // checked frames needed at the end
	localparam int BLANK_DIGIT    = -1;
	localparam int UNKNOWN_DIGIT  = -2;
	localparam logic [6:0] DARK   = 7'b1111111;

	logic                  CLK = 1'b0;
	logic                  reset;
	logic                  load_strobe;
	bcd_value_t            load_value;
	logic [num_digits-1:0] anodes;
	seg_pattern_t          segments;

	int                    run_cycle    = 0;     // cycles since reset release
	int                    total_cycles = 0;
	int                    last_change  = -1;    // first cycle the counter holds a new value
	int                    counts_seen  = 0;
	int                    frames_checked = 0;
	int                    digit_cycles = 0;
	int                    lit_cycles   = 0;
	int                    cur_digit    = 0;
	logic                  saw_max      = 1'b0;  // a whole frame of 9999
	logic                  saw_wrap     = 1'b0;  // 0000 after the 9999
	logic [num_digits-1:0] prev_anodes  = '0;
	logic [6:0]            lit_mask     = '0;    // segments seen low in this digit
	bcd_value_t            model_value  = '0;    // expected counter value
	bcd_value_t            digit_value [num_digits];
	logic                  digit_ok    [num_digits];

	display_top #(
		.SLOT_BITS  (SLOT_BITS),
		.COUNT_BITS (COUNT_BITS)
	) uut (
		.CLK         (CLK),
		.reset       (reset),
		.load_strobe (load_strobe),
		.load_value  (load_value),
		.anodes      (anodes),
		.segments    (segments)
	);

	always #2 CLK = ~CLK; // 4 ns period

	task automatic report_failure(input string message);
		$display("[ERROR] %0t ns: %s", $time, message);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	function automatic bcd_value_t make_bcd(input int number);
		bcd_value_t value;
		value.thousands = 4'((number / 1000) % 10);
		value.hundreds  = 4'((number / 100) % 10);
		value.tens      = 4'((number / 10) % 10);
		value.units     = 4'(number % 10);
		return value;
	endfunction

	function automatic bcd_value_t increment_bcd(input bcd_value_t value);
		int number;
		number = int'(value.thousands) * 1000 + int'(value.hundreds) * 100;
		number = number + int'(value.tens) * 10 + int'(value.units);
		return make_bcd((number + 1) % 10000); // 9999 wraps to 0000
	endfunction

	// digit shown at a position once leading zeros are blanked
	function automatic int expected_digit(input bcd_value_t value, input int index);
		logic [3:0] nibble [num_digits];
		nibble[0] = value.units;
		nibble[1] = value.tens;
		nibble[2] = value.hundreds;
		nibble[3] = value.thousands;
		for (int i = index; i < num_digits; i++) begin
			if (nibble[i] != 4'd0) begin
				return int'(nibble[index]);
			end
		end
		return (index == 0) ? 0 : BLANK_DIGIT; // units always shows
	endfunction

	// active low pattern back to a digit
	function automatic int pattern_digit(input logic [6:0] pattern);
		case (pattern)
			7'b0000001 : return 0;
			7'b1001111 : return 1;
			7'b0010010 : return 2;
			7'b0000110 : return 3;
			7'b1001100 : return 4;
			7'b0100100 : return 5;
			7'b0100000 : return 6;
			7'b0001111 : return 7;
			7'b0000000 : return 8;
			7'b0000100 : return 9;
			7'b1111111 : return BLANK_DIGIT;
			default    : return UNKNOWN_DIGIT;
		endcase
	endfunction

	function automatic int anode_index(input logic [num_digits-1:0] onehot);
		for (int i = 0; i < num_digits; i++) begin
			if (onehot[i]) begin
				return i;
			end
		end
		return 0;
	endfunction

	// compare one finished digit and close the frame after the thousands
	task automatic finish_digit(input int index);
		int   read;
		logic frame_good;
		read = pattern_digit(~lit_mask);
		assert (read != UNKNOWN_DIGIT)
			else report_failure($sformatf("digit %0d shows unknown pattern %b", index, ~lit_mask));
		if (digit_ok[index]) begin
			assert (read == expected_digit(digit_value[index], index))
				else report_failure($sformatf("digit %0d reads %0d, expected %0d of %h", index,
					read, expected_digit(digit_value[index], index), digit_value[index]));
		end
		if (index == num_digits - 1) begin
			frame_good = 1'b1;
			for (int i = 0; i < num_digits; i++) begin
				frame_good = frame_good && digit_ok[i] && (digit_value[i] == digit_value[0]);
			end
			if (frame_good) begin
				frames_checked++;
				saw_wrap = saw_wrap || (saw_max && digit_value[0] == 16'h0000);
				saw_max  = saw_max || (digit_value[0] == 16'h9999);
			end
		end
	endtask

	// sampled away from the drive edge
	always @(negedge CLK) begin
		if (reset) begin
			assert (anodes == '0 && segments == DARK) else report_failure("display lit in reset");
		end else begin
			if (run_cycle < SLOT_CYCLES) begin
				assert (anodes == '0 && segments == DARK)
					else report_failure("display lit before the first slot");
			end
			if (anodes != prev_anodes) begin
				if (prev_anodes == '0) begin
					assert (anodes == 4'b0001)
						else report_failure($sformatf("scan started with anodes %b", anodes));
				end else begin
					assert (anodes == {prev_anodes[num_digits-2:0], prev_anodes[num_digits-1]})
						else report_failure($sformatf("anodes %b followed %b", anodes, prev_anodes));
					assert (digit_cycles == DIGIT_CYCLES)
						else report_failure($sformatf("digit lasted %0d cycles", digit_cycles));
					assert (lit_cycles <= 7 * SLOT_CYCLES)
						else report_failure($sformatf("%0d lit cycles in one digit", lit_cycles));
					finish_digit(cur_digit);
				end
				cur_digit              = anode_index(anodes);
				digit_value[cur_digit] = model_value;              // value the scanner just latched
				digit_ok[cur_digit]    = (last_change < run_cycle); // no change at the latch edge
				lit_mask               = '0;
				digit_cycles           = 0;
				lit_cycles             = 0;
			end
			digit_cycles++;
			if (segments != DARK) begin
				lit_cycles++;
				lit_mask = lit_mask | ~segments;
			end
			if (load_strobe) begin
				model_value = load_value; // load beats the count strobe
				last_change = run_cycle + 1;
			end else if (run_cycle % COUNT_CYCLES == COUNT_CYCLES - 1) begin
				model_value = increment_bcd(model_value);
				last_change = run_cycle + 1;
			end
			if (run_cycle % COUNT_CYCLES == COUNT_CYCLES - 1) begin
				counts_seen++;
			end
			prev_anodes = anodes;
			run_cycle++;
		end
	end

	assert property (@(posedge CLK) disable iff (reset) $onehot0(anodes))
		else report_failure("more than one anode high");
	assert property (@(posedge CLK) disable iff (reset) $onehot0(~segments))
		else report_failure("more than one segment lit");
	assert property (@(posedge CLK) disable iff (reset) (anodes == '0) |-> (segments == DARK))
		else report_failure("segment lit with every anode off");

	always @(posedge CLK) begin
		total_cycles++;
		if (total_cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$fatal(1, "timeout");
		end
	end

	task automatic wait_for_count();
		int target;
		target = counts_seen + 1;
		while (counts_seen < target) begin
			@(posedge CLK);
		end
	endtask

	task automatic wait_for_frames(input int count);
		int target;
		target = frames_checked + count;
		while (frames_checked < target) begin
			@(posedge CLK);
		end
	endtask

	task automatic apply_load(input bcd_value_t value);
		load_strobe <= 1'b1;
		load_value  <= value;
		@(posedge CLK);
		load_strobe <= 1'b0;
	endtask

	initial begin
		void'($urandom(32'h2f701555));
		reset       = 1'b1;
		load_strobe = 1'b0;
		load_value  = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		reset <= 1'b0;
		wait_for_count();            // 0000 shown as a lone 0 until here
		apply_load(16'h9999);
		wait_for_count();            // wraps to 0000
		wait_for_count();
		apply_load(16'h0000);
		wait_for_count();
		apply_load(16'h0048);        // two leading zeros and every segment of the units
		wait_for_count();
		apply_load(make_bcd(int'($urandom % 10000)));
		wait_for_count();
		apply_load(make_bcd(int'($urandom % 10000)));
		wait_for_count();
		repeat (1 + ($urandom % FRAME_CYCLES)) @(posedge CLK); // load lands mid frame
		apply_load(make_bcd(int'($urandom % 10000)));
		wait_for_count();            // loaded value plus one
		wait_for_frames(2);
		if (saw_max && saw_wrap && frames_checked >= MIN_FRAMES) begin
			$display("** PASS **");
			$finish;
		end else begin
			report_failure($sformatf("only %0d frames checked or 9999 wrap not seen",
				frames_checked));
		end
	end

endmodule

//--- source/display_top.sv
// ***************************************
// display top
// counter and time sliced 4 digit seven segment driver
// ***************************************
`timescale 1ns/1ps

module display_top
	import display_pkg::*;
#(
	parameter int SLOT_BITS  = 10, // slot length is 2**SLOT_BITS cycles
	parameter int COUNT_BITS = 24  // count period needs at least SLOT_BITS + 5 bits
) (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  load_strobe, // single cycle load
	input  bcd_value_t            load_value,  // valid with load_strobe
	output logic [num_digits-1:0] anodes,      // active high with bit 0 units
	output seg_pattern_t          segments     // active low a to g
);

	logic            slot_tick;      // end of a segment slot
	logic            count_tick;     // advance the counter
	bcd_value_t      count_value;    // counter value
	digit_patterns_t digit_patterns; // decoded patterns for all digits
	slot_t           slot;           // scanner slot
	seg_pattern_t    pattern;        // latched pattern for the digit that is on

	tick_generator #(
		.SLOT_BITS  (SLOT_BITS),
		.COUNT_BITS (COUNT_BITS)
	) tick_gen (
		.CLK        (CLK),
		.reset      (reset),
		.slot_tick  (slot_tick),
		.count_tick (count_tick)
	);

	bcd_counter counter (
		.CLK         (CLK),
		.reset       (reset),
		.count_tick  (count_tick),
		.load_strobe (load_strobe),
		.load_value  (load_value),
		.count_value (count_value)
	);

	seven_seg_decoder decoder (
		.count_value    (count_value),
		.digit_patterns (digit_patterns)
	);

	digit_scanner scanner (
		.CLK            (CLK),
		.reset          (reset),
		.slot_tick      (slot_tick),
		.digit_patterns (digit_patterns),
		.anodes         (anodes),
		.slot           (slot),
		.pattern        (pattern)
	);

	segment_sequencer sequencer (
		.CLK      (CLK),
		.reset    (reset),
		.slot     (slot),
		.pattern  (pattern),
		.segments (segments)
	);

endmodule

//--- source/segment_sequencer.sv
// ***************************************
// segment sequencer
// lights one segment of the current pattern per slot
// ***************************************
`timescale 1ns/1ps

module segment_sequencer
	import display_pkg::*;
(
	input  logic         CLK,
	input  logic         reset,
	input  slot_t        slot,    // slot now running in the scanner
	input  seg_pattern_t pattern, // latched digit pattern
	output seg_pattern_t segments // active low to the cathode pins
);

	seg_pattern_t slot_mask;     // one hot mask of the segment for this slot
	seg_pattern_t next_segments; // value for the output register

	// pick the single segment this slot may drive
	always_comb begin
		case (slot)
			slot_a  : slot_mask = 7'b1000000;
			slot_b  : slot_mask = 7'b0100000;
			slot_c  : slot_mask = 7'b0010000;
			slot_d  : slot_mask = 7'b0001000;
			slot_e  : slot_mask = 7'b0000100;
			slot_f  : slot_mask = 7'b0000010;
			slot_g  : slot_mask = 7'b0000001;
			default : slot_mask = 7'b0000000; // slot_blank keeps all dark
		endcase
	end

	// force every segment outside the mask to off
	// and pass the masked one through from the pattern
	assign next_segments = pattern | ~slot_mask;

	always_ff @(posedge CLK) begin
		if (reset) begin
			segments <= blank_pattern; // dark out of reset
		end else begin
			segments <= next_segments; // one cycle behind the slot
		end
	end

	// at most one bit of segments is ever low
	// so the current through each anode resistor
	// is that of a single segment whatever the digit

	// a segment that the pattern leaves off
	// just gives a dark slot of the same length

	// a digit therefore shows at most 7 lit slots
	// followed by the blank slot

	// slot_blank gives 2**SLOT_BITS cycles of dead time
	// before the scanner moves the anode on

	// the output is registered so the pins change
	// cleanly on CLK with no decode glitches

	// a unknown pattern before the first latch
	// is masked to all ones in slot_blank

	// decimal point and colon are not driven here
	// and stay tied off on the board

	// brightness is fixed by the slot length and the resistor
	// since every segment gets the same share of the frame

	// one segment in 32 slots is the duty cycle
	// seen by any single segment

	// this is the time sliced version of the digit multiplexing
	// with slots taking the place of whole digit times

	// segments are active low so blank is all ones

	// the slot encoding in the package fixes the order a to g

endmodule

//--- source/digit_scanner.sv
// ***************************************
// digit scanner
// steps segment slots and digits and drives the anodes
// ***************************************
`timescale 1ns/1ps

module digit_scanner
	import display_pkg::*;
(
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  slot_tick,      // advance one slot
	input  digit_patterns_t       digit_patterns, // from the decoder
	output logic [num_digits-1:0] anodes,         // active high with bit 0 units
	output slot_t                 slot,           // segment slot now running
	output seg_pattern_t          pattern         // pattern of the digit that is on
);

	localparam int DIGIT_BITS = $clog2(num_digits); // width of the digit index

	logic [DIGIT_BITS-1:0] digit;      // 0 units up to 3 thousands
	logic [DIGIT_BITS-1:0] next_digit; // digit that starts after the blank slot
	logic                  digit_end;  // slot tick that closes a digit

	assign next_digit = digit + 1'b1; // thousands wraps round to units
	assign digit_end  = slot_tick && (slot == slot_blank);

	// slot sequence a to g then blank
	always_ff @(posedge CLK) begin
		if (reset) begin
			slot <= slot_blank; // first tick opens slot_a
		end else if (slot_tick) begin
			if (slot == slot_blank) begin
				slot <= slot_a; // start of the next digit
			end else begin
				slot <= slot_t'(slot + 3'd1);
			end
		end
	end

	// digit index and one hot anode
	always_ff @(posedge CLK) begin
		if (reset) begin
			digit  <= DIGIT_BITS'(num_digits - 1); // first tick moves on to units
			anodes <= '0;                          // display dark
		end else if (digit_end) begin
			digit  <= next_digit;
			anodes <= {{(num_digits-1){1'b0}}, 1'b1} << next_digit;
		end
	end

	// pattern held for the whole digit time
	always_ff @(posedge CLK) begin
		if (digit_end) begin
			pattern <= digit_patterns[next_digit]; // latched as slot_a begins
		end
	end

	// a digit is 8 slots and a frame is 32 slots
	// so a frame is 2**(SLOT_BITS+5) cycles

	// the anode switches in the same cycle as the slot goes to slot_a
	// and the sequencer follows a cycle later
	// so segments lag the anodes by one cycle

	// the previous anode stays high through its own blank slot
	// but the sequencer holds every segment dark there
	// so no segment is lit when the anode moves on

	// before the first slot tick the anodes are all zero
	// and the slot is slot_blank so the display stays dark

	// the count strobe lands in the thousands blank slot
	// so a whole frame always shows one value

endmodule

//--- source/seven_seg_decoder.sv
// ***************************************
// seven segment decoder
// BCD digits to active low patterns with leading zero blanking
// ***************************************
`timescale 1ns/1ps

module seven_seg_decoder
	import display_pkg::*;
(
	input  bcd_value_t      count_value,
	output digit_patterns_t digit_patterns // index 0 is units
);

	logic [num_digits-1:0][3:0] digits;  // units at index 0
	logic [num_digits-1:0]      blanked; // digit dropped as a leading zero
	logic [num_digits:0]        leading; // still inside the leading zeros

	assign digits = count_value;

	// walk down from the thousands digit
	always_comb begin
		leading[num_digits] = 1'b1; // nothing above the thousands digit
		for (int i = num_digits - 1; i >= 0; i--) begin
			if (i == 0) begin
				blanked[i] = 1'b0; // units always shows
			end else begin
				blanked[i] = leading[i+1] && (digits[i] == 4'd0);
			end
			leading[i] = blanked[i];
		end
	end

	// table lookup or dark digit
	always_comb begin
		for (int i = 0; i < num_digits; i++) begin
			if (blanked[i]) begin
				digit_patterns[i] = blank_pattern;
			end else begin
				digit_patterns[i] = bcd_to_pattern(digits[i]); // 10 to 15 come back blank
			end
		end
	end

	// a zero in the middle of the number is not blanked
	// since leading drops as soon as a nonzero digit is seen
	// so 1005 reads as 1 0 0 5 and 0050 as blank blank 5 0

	// 0000 gives three blank digits and a single 0 at the units

	// a non decimal nibble also ends the leading run
	// and shows dark itself

	// purely combinational so the patterns follow count_value
	// within the same cycle

	// the scanner latches one digit at a time from this bus
	// so a change here never tears a digit that is on

	// no decimal point or colon is driven from here

endmodule

//--- source/bcd_counter.sv
// ***************************************
// bcd counter
// four digit decimal event counter with a direct load
// ***************************************
`timescale 1ns/1ps

module bcd_counter
	import display_pkg::*;
(
	input  logic       CLK,
	input  logic       reset,
	input  logic       count_tick,  // advance by one
	input  logic       load_strobe, // single cycle load request
	input  bcd_value_t load_value,  // valid with load_strobe
	output bcd_value_t count_value
);

	logic [num_digits-1:0][3:0] digits;      // current value with units at index 0
	logic [num_digits-1:0][3:0] next_digits; // value plus one
	logic [num_digits:0]        carry;       // carry into each digit

	assign digits = count_value; // same bit layout as the struct

	// ripple the increment up the digits
	always_comb begin
		carry[0] = 1'b1; // always adding one at the units
		for (int i = 0; i < num_digits; i++) begin
			if (!carry[i]) begin
				next_digits[i] = digits[i]; // no carry so hold
				carry[i+1]     = 1'b0;
			end else if (digits[i] >= 4'd9) begin
				next_digits[i] = 4'd0; // roll over and carry on
				carry[i+1]     = 1'b1;
			end else begin
				next_digits[i] = digits[i] + 4'd1;
				carry[i+1]     = 1'b0;
			end
		end
	end

	// carry out of the thousands digit is simply dropped
	// so 9999 wraps to 0000

	always_ff @(posedge CLK) begin
		if (reset) begin
			count_value <= '0; // start at 0000
		end else if (load_strobe) begin
			count_value <= load_value; // load beats a count in the same cycle
		end else if (count_tick) begin
			count_value <= bcd_value_t'(next_digits);
		end
	end

	// a load is taken without any handshake
	// and load_value is only looked at in the load cycle

	// the new value shows up one cycle after either strobe

	// a nibble above 9 from a bad load rolls to 0 on the next count
	// and reads as blank in the decoder until then

	// the carry chain is short enough at 4 digits
	// to settle well within one CLK period

	// count_value feeds the decoder directly
	// and the scanner latches the result at digit boundaries

	// the counter runs the same whether or not anything is displayed
	// since the scanner never holds it off

	// reset only clears the value and does not touch the strobes

endmodule

//--- source/tick_generator.sv
// ***************************************
// tick generator
// free running prescaler making the slot and count strobes
// ***************************************
`timescale 1ns/1ps

module tick_generator #(
	parameter int SLOT_BITS  = 10, // slot lasts 2**SLOT_BITS cycles
	parameter int COUNT_BITS = 24  // count period is 2**COUNT_BITS cycles
) (
	input  logic CLK,
	input  logic reset,
	output logic slot_tick,  // one cycle at the end of each slot
	output logic count_tick  // one cycle at the end of each count period
);

	// COUNT_BITS has to be at least SLOT_BITS + 5 so that the count
	// period is a whole number of 32 slot frames and the strobe falls
	// in the last slot of a frame

	logic [COUNT_BITS-1:0] prescale; // free running cycle count
	logic                  slot_ones;  // low slot field all ones
	logic                  count_ones; // whole prescaler all ones

	always_ff @(posedge CLK) begin
		if (reset) begin
			prescale <= '0; // both strobes stay low while held here
		end else begin
			prescale <= prescale + 1'b1; // wraps freely
		end
	end

	// enables on CLK instead of derived clocks
	assign slot_ones  = &prescale[SLOT_BITS-1:0];
	assign count_ones = &prescale;

	assign slot_tick  = slot_ones;  // every 2**SLOT_BITS cycles
	assign count_tick = count_ones; // every 2**COUNT_BITS cycles

	// a count tick always coincides with a slot tick
	// since the slot field is the low part of the same counter

	// with the board defaults at 100 MHz a slot is about 10 us
	// and the count period about 168 ms

	// the first slot tick after reset comes at cycle 2**SLOT_BITS - 1
	// which starts the units digit in the scanner

	// the first count tick comes at cycle 2**COUNT_BITS - 1
	// which is the start of the blank slot of the thousands digit
	// so the new value is ready before the next units latch

	// nothing downstream can stall this counter

endmodule

//--- source/display_pkg.sv
// ***************************************
// display package
// types and segment table for the 4 digit multiplexed display
// ***************************************
package display_pkg;

	localparam int num_digits = 4; // digits on the board display

	// one BCD digit per field with thousands in the top nibble
	typedef struct packed {
		logic [3:0] thousands; // most significant digit
		logic [3:0] hundreds;
		logic [3:0] tens;
		logic [3:0] units;     // least significant digit
	} bcd_value_t;

	// segment a in bit 6 down to segment g in bit 0
	typedef logic [6:0] seg_pattern_t; // active low so a 0 lights the segment

	typedef seg_pattern_t [num_digits-1:0] digit_patterns_t; // index 0 is units

	// one slot per segment plus a dark slot between digits
	typedef enum logic [2:0] {
		slot_a,
		slot_b,
		slot_c,
		slot_d,
		slot_e,
		slot_f,
		slot_g,
		slot_blank // dead time before the next anode
	} slot_t;

	localparam seg_pattern_t blank_pattern = 7'b1111111; // every segment off

	// common anode table for 0 to 9
	function automatic seg_pattern_t bcd_to_pattern(input logic [3:0] digit);
		case (digit)
			4'd0    : return 7'b0000001; // g dark
			4'd1    : return 7'b1001111; // b and c only
			4'd2    : return 7'b0010010;
			4'd3    : return 7'b0000110;
			4'd4    : return 7'b1001100;
			4'd5    : return 7'b0100100;
			4'd6    : return 7'b0100000;
			4'd7    : return 7'b0001111;
			4'd8    : return 7'b0000000; // all lit
			4'd9    : return 7'b0000100;
			default : return blank_pattern; // not a decimal digit
		endcase
	endfunction

endpackage
